// ==== hw/remote_pkg.sv ====
// Shared widths and FSM state types for the remote command link RTL, referenced by scoped name.
package remote_pkg;

  //////////////////////////////////////////////////
  // Data widths
  //////////////////////////////////////////////////
  localparam int BYTE_W = 8;   // One serial data byte.
  localparam int CMD_W  = 16;  // Host command word, sent as two bytes.

  //////////////////////////////////////////////////
  // Command splitter states
  //////////////////////////////////////////////////
  // High byte goes out on the accept cycle, so only the low byte needs a state.
  typedef enum logic {
    SPLIT_IDLE,  // Waiting for snd_cmd.
    LOW_BYTE     // Pushing the latched low byte.
  } split_state_t;

  //////////////////////////////////////////////////
  // Serial engine phases
  //////////////////////////////////////////////////
  // Shared by the transmitter and the receiver.
  typedef enum logic [1:0] {
    IDLE,   // Line idle, high.
    START,  // Start bit.
    DATA,   // Eight data bits, LSB first.
    STOP    // Stop bit.
  } uart_state_t;

endpackage

// ==== hw/cmd_splitter.sv ====
// Command producer: splits each accepted 16-bit command into two FIFO pushes and owns cmd_snt.
module cmd_splitter #(
  parameter int FIFO_DEPTH = 4  // Entries in the byte FIFO.
) (
  input  logic                            clk,         // System clock.
  input  logic                            rst_n,       // Async active low reset.
  input  logic                            snd_cmd,     // One-cycle send strobe.
  input  logic [remote_pkg::CMD_W-1:0]    cmd,         // Command word, valid with snd_cmd.
  input  logic [$clog2(FIFO_DEPTH+1)-1:0] free_cnt,    // Free FIFO entries.
  input  logic                            frame_done,  // Last byte of a command left the wire.
  output logic                            cmd_rdy,     // Splitter can take a command.
  output logic                            cmd_snt,     // Previous command fully sent.
  output logic                            push,        // Write strobe into the FIFO.
  output logic [remote_pkg::BYTE_W-1:0]   push_data,   // Byte to queue.
  output logic                            push_last    // End-of-command tag.
);

  localparam int FREE_W = $clog2(FIFO_DEPTH + 1);

  remote_pkg::split_state_t      state;     // Current splitter state.
  logic                          accept;    // Command taken this cycle.
  logic [remote_pkg::BYTE_W-1:0] low_byte;  // Low byte held for the second push.

  //////////////////////////////////////////////////
  // Handshake and push steering
  //////////////////////////////////////////////////
  // Both bytes must fit, so ask for two free entries.
  assign cmd_rdy = (state == remote_pkg::SPLIT_IDLE) && (free_cnt >= FREE_W'(2));
  assign accept  = snd_cmd && cmd_rdy;  // Strobes while not ready are dropped.

  assign push      = accept || (state == remote_pkg::LOW_BYTE);  // High byte, then low byte.
  assign push_last = (state == remote_pkg::LOW_BYTE);            // Only the low byte ends it.
  assign push_data = (state == remote_pkg::LOW_BYTE) ?
                     low_byte : cmd[remote_pkg::CMD_W-1:remote_pkg::BYTE_W];

  //////////////////////////////////////////////////
  // State register and cmd_snt flag
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= remote_pkg::SPLIT_IDLE;  // Ready after reset.
      cmd_snt <= 1'b0;                    // Nothing sent yet.
    end else begin
      case (state)
        remote_pkg::SPLIT_IDLE: if (accept) state <= remote_pkg::LOW_BYTE;
        default:                state <= remote_pkg::SPLIT_IDLE;  // Low byte pushed now.
      endcase
      if (accept) begin
        cmd_snt <= 1'b0;  // New command in flight.
      end else if (frame_done) begin
        cmd_snt <= 1'b1;  // Holds until the next accept.
      end
    end
  end

  // Low byte is payload only, captured on accept.
  always_ff @(posedge clk) begin
    if (accept) begin
      low_byte <= cmd[remote_pkg::BYTE_W-1:0];
    end
  end

endmodule

// ==== hw/byte_fifo.sv ====
// Circular byte queue between splitter and transmitter; each entry carries an end-of-command tag.
module byte_fifo #(
  parameter int FIFO_DEPTH = 4  // Power of two, at least 2.
) (
  input  logic                            clk,        // System clock.
  input  logic                            rst_n,      // Async active low reset.
  input  logic                            push,       // Write strobe.
  input  logic [remote_pkg::BYTE_W-1:0]   push_data,  // Byte to write.
  input  logic                            push_last,  // Tag of the byte to write.
  input  logic                            pop,        // Take the head entry.
  output logic                            empty,      // No entries held.
  output logic [$clog2(FIFO_DEPTH+1)-1:0] free_cnt,   // Entries still free.
  output logic [remote_pkg::BYTE_W-1:0]   pop_data,   // Head byte.
  output logic                            pop_last    // Head tag.
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [remote_pkg::BYTE_W:0] mem [FIFO_DEPTH];  // Tag in the top bit.
  logic [PTR_W-1:0]            wr_ptr;            // Next slot to write.
  logic [PTR_W-1:0]            rd_ptr;            // Head slot.
  logic [CNT_W-1:0]            count;             // Occupancy.
  logic                        do_push;           // Qualified write.
  logic                        do_pop;            // Qualified read.

  assign do_push = push && (count != CNT_W'(FIFO_DEPTH));  // Never overwrite the head.
  assign do_pop  = pop && !empty;

  assign empty    = (count == '0);
  assign free_cnt = CNT_W'(FIFO_DEPTH) - count;
  assign pop_data = mem[rd_ptr][remote_pkg::BYTE_W-1:0];
  assign pop_last = mem[rd_ptr][remote_pkg::BYTE_W];

  // Pointers wrap naturally since depth is a power of two.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither.
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= {push_last, push_data};
    end
  end

endmodule

// ==== hw/uart_tx.sv ====
// 8N1 serializer: pops FIFO entries while idle and flags the end of each tagged command byte.
module uart_tx #(
  parameter int BAUD_DIV = 8  // Clock cycles per bit, 4 or more.
) (
  input  logic                          clk,         // System clock.
  input  logic                          rst_n,       // Async active low reset.
  input  logic                          empty,       // FIFO has nothing to send.
  input  logic [remote_pkg::BYTE_W-1:0] pop_data,    // Head byte.
  input  logic                          pop_last,    // Head is last byte of a command.
  output logic                          pop,         // Take the head entry.
  output logic                          tx,          // Serial line out.
  output logic                          frame_done   // Tagged frame just finished.
);

  localparam int CNT_W = $clog2(BAUD_DIV);
  localparam int IDX_W = $clog2(remote_pkg::BYTE_W);

  remote_pkg::uart_state_t       state;      // Frame phase.
  logic [CNT_W-1:0]              baud_cnt;   // Cycle within the bit.
  logic [IDX_W-1:0]              bit_idx;    // Data bit on the line.
  logic [remote_pkg::BYTE_W-1:0] shift_reg;  // Bits still to send.
  logic                          last_q;     // Tag for the frame in flight.
  logic                          baud_end;   // Final cycle of a bit.

  assign baud_end   = (baud_cnt == CNT_W'(BAUD_DIV - 1));
  assign pop        = (state == remote_pkg::IDLE) && !empty;
  assign frame_done = (state == remote_pkg::STOP) && baud_end && last_q;

  //////////////////////////////////////////////////
  // Frame sequencer
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= remote_pkg::IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b1;  // Idle line.
      last_q   <= 1'b0;
    end else begin
      if (state == remote_pkg::IDLE) baud_cnt <= '0;
      else                           baud_cnt <= baud_end ? '0 : baud_cnt + 1'b1;
      case (state)
        remote_pkg::IDLE: if (pop) begin
          state  <= remote_pkg::START;
          tx     <= 1'b0;      // Start bit from the next edge.
          last_q <= pop_last;
        end
        remote_pkg::START: if (baud_end) begin
          state   <= remote_pkg::DATA;
          tx      <= shift_reg[0];  // LSB first.
          bit_idx <= '0;
        end
        remote_pkg::DATA: if (baud_end) begin
          if (bit_idx == IDX_W'(remote_pkg::BYTE_W - 1)) begin
            state <= remote_pkg::STOP;
            tx    <= 1'b1;  // Stop bit.
          end else begin
            tx      <= shift_reg[0];
            bit_idx <= bit_idx + 1'b1;
          end
        end
        default: if (baud_end) state <= remote_pkg::IDLE;  // Line stays high.
      endcase
    end
  end

  // Shift register is payload; loaded on pop, shifted as each bit goes out.
  always_ff @(posedge clk) begin
    if (pop) begin
      shift_reg <= pop_data;
    end else if (baud_end && (state == remote_pkg::START || state == remote_pkg::DATA)) begin
      shift_reg <= shift_reg >> 1;
    end
  end

endmodule

// ==== hw/uart_rx.sv ====
// 8N1 deserializer for the response line: mid-bit sampling, holds the last byte with a ready flag.
module uart_rx #(
  parameter int BAUD_DIV = 8  // Clock cycles per bit, 4 or more.
) (
  input  logic                          clk,       // System clock.
  input  logic                          rst_n,     // Async active low reset.
  input  logic                          rx,        // Serial line in, asynchronous.
  output logic [remote_pkg::BYTE_W-1:0] resp,      // Last received byte.
  output logic                          resp_rdy   // resp holds a fresh byte.
);

  localparam int CNT_W = $clog2(BAUD_DIV);
  localparam int IDX_W = $clog2(remote_pkg::BYTE_W);

  remote_pkg::uart_state_t       state;      // Frame phase.
  logic                          rx_ff1;     // First sync stage.
  logic                          rx_s;       // Synchronized line.
  logic [CNT_W-1:0]              baud_cnt;   // Cycle within the bit.
  logic [IDX_W-1:0]              bit_idx;    // Data bit being sampled.
  logic [remote_pkg::BYTE_W-1:0] shift_reg;  // Bits gathered so far.
  logic                          baud_end;   // Mid-bit sample point.
  logic                          half_end;   // Middle of the start bit.
  logic                          restart;    // Counter wraps this cycle.

  assign baud_end = (baud_cnt == CNT_W'(BAUD_DIV - 1));
  assign half_end = (baud_cnt == CNT_W'(BAUD_DIV / 2 - 1));
  assign restart  = (state == remote_pkg::START) ? half_end : baud_end;

  //////////////////////////////////////////////////
  // Synchronizer and frame sequencer
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_ff1   <= 1'b1;  // Line idles high.
      rx_s     <= 1'b1;
      state    <= remote_pkg::IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      resp     <= '0;
      resp_rdy <= 1'b0;
    end else begin
      rx_ff1 <= rx;
      rx_s   <= rx_ff1;
      if (state == remote_pkg::IDLE) baud_cnt <= '0;
      else                           baud_cnt <= restart ? '0 : baud_cnt + 1'b1;
      case (state)
        remote_pkg::IDLE: if (!rx_s) begin
          state    <= remote_pkg::START;  // Falling edge seen.
          resp_rdy <= 1'b0;               // Previous byte goes stale.
        end
        remote_pkg::START: if (half_end) begin
          state   <= rx_s ? remote_pkg::IDLE : remote_pkg::DATA;  // Glitch rejects.
          bit_idx <= '0;
        end
        remote_pkg::DATA: if (baud_end) begin
          bit_idx <= bit_idx + 1'b1;
          if (bit_idx == IDX_W'(remote_pkg::BYTE_W - 1)) state <= remote_pkg::STOP;
        end
        default: if (baud_end) begin
          resp     <= shift_reg;  // Middle of stop bit.
          resp_rdy <= 1'b1;
          state    <= remote_pkg::IDLE;
        end
      endcase
    end
  end

  // LSB arrives first, so shift in from the top.
  always_ff @(posedge clk) begin
    if (state == remote_pkg::DATA && baud_end) begin
      shift_reg <= {rx_s, shift_reg[remote_pkg::BYTE_W-1:1]};
    end
  end

endmodule

// ==== hw/remote_comm.sv ====
// Top of the remote command link; connects splitter, FIFO, UART TX and RX and sets the parameters.
module remote_comm #(
  parameter int BAUD_DIV   = 8,  // Clock cycles per serial bit.
  parameter int FIFO_DEPTH = 4   // Byte entries in the queue.
) (
  input  logic                          clk,       // System clock.
  input  logic                          rst_n,     // Async active low reset.
  input  logic                          snd_cmd,   // One-cycle send strobe.
  input  logic [remote_pkg::CMD_W-1:0]  cmd,       // Command word.
  output logic                          cmd_rdy,   // Command can be taken.
  output logic                          cmd_snt,   // Last command fully on the wire.
  input  logic                          rx,        // Response line in.
  output logic                          tx,        // Command line out.
  output logic [remote_pkg::BYTE_W-1:0] resp,      // Received response byte.
  output logic                          resp_rdy   // Response valid.
);

  //////////////////////////////////////////////////
  // Internal links
  //////////////////////////////////////////////////
  logic                            push;        // Splitter to FIFO.
  logic [remote_pkg::BYTE_W-1:0]   push_data;
  logic                            push_last;
  logic [$clog2(FIFO_DEPTH+1)-1:0] free_cnt;    // FIFO space back to splitter.
  logic                            empty;       // FIFO to transmitter.
  logic [remote_pkg::BYTE_W-1:0]   pop_data;
  logic                            pop_last;
  logic                            pop;         // Transmitter takes head.
  logic                            frame_done;  // Tagged frame finished.

  cmd_splitter #(.FIFO_DEPTH(FIFO_DEPTH)) u_splitter (
    .clk, .rst_n, .snd_cmd, .cmd, .free_cnt, .frame_done,
    .cmd_rdy, .cmd_snt, .push, .push_data, .push_last
  );

  byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clk, .rst_n, .push, .push_data, .push_last, .pop,
    .empty, .free_cnt, .pop_data, .pop_last
  );

  uart_tx #(.BAUD_DIV(BAUD_DIV)) u_tx (
    .clk, .rst_n, .empty, .pop_data, .pop_last,
    .pop, .tx, .frame_done
  );

  uart_rx #(.BAUD_DIV(BAUD_DIV)) u_rx (
    .clk, .rst_n, .rx, .resp, .resp_rdy
  );

endmodule

// ==== sim/remote_comm_tb.sv ====
// Testbench for the remote command link: reads the case file, sends commands and responses, checks.
module remote_comm_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int        CLK_PERIOD = 100;                     // ns.
  localparam int        RESET_CYC  = 16;                      // Cycles held in reset.
  localparam int        BAUD_DIV   = 8;                       // Handed to the DUT.
  localparam int        FIFO_DEPTH = 4;                       // Handed to the DUT.
  localparam int        FRAME_CYC  = 10 * BAUD_DIV;           // One 8N1 frame.
  localparam int        MAX_CASES  = 64;
  localparam bit [31:0] SEED       = 32'h9fc1a809;
  localparam string     CASE_FILE  = "sim/remote_cases.txt";

  logic                          clk;
  logic                          rst_n;
  logic                          snd_cmd;   // Host strobe.
  logic [remote_pkg::CMD_W-1:0]  cmd;
  logic                          cmd_rdy;
  logic                          cmd_snt;
  logic                          rx;        // Response line into the DUT.
  logic                          tx;        // Command line out of the DUT.
  logic [remote_pkg::BYTE_W-1:0] resp;
  logic                          resp_rdy;

  logic [remote_pkg::CMD_W-1:0]  case_cmd  [MAX_CASES];  // Command per case.
  logic [remote_pkg::BYTE_W-1:0] case_resp [MAX_CASES];  // Response per case.
  bit                            case_flag [MAX_CASES];  // Next case back-to-back.
  int                            n_cases;
  int                            errors;                 // Failed checks so far.
  int                            cycle;                  // Rising edges seen.

  remote_comm #(.BAUD_DIV(BAUD_DIV), .FIFO_DEPTH(FIFO_DEPTH)) DUT (
    .clk, .rst_n, .snd_cmd, .cmd, .cmd_rdy, .cmd_snt, .rx, .tx, .resp, .resp_rdy
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;  // Time base for frame spacing.

  //////////////////////////////////////////////////
  // Checking helpers
  //////////////////////////////////////////////////
  task automatic check(input bit cond, input string msg);
    assert (cond) else begin
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      errors++;
    end
  endtask

  // Finds a start bit on tx, then samples each bit in its middle.
  task automatic decode_frame(output logic [7:0] data, output int start_cyc);
    int waited;
    waited = 0;
    data = '0;
    start_cyc = -1;
    while (tx !== 1'b0 && waited < 4 * FRAME_CYC) begin
      @(negedge clk);
      waited++;
    end
    assert (tx === 1'b0) else begin
      $display("ERROR at %0t ns: no frame started on tx", $time);
      errors++;
    end
    if (tx === 1'b0) begin
      start_cyc = cycle;
      repeat (BAUD_DIV / 2) @(negedge clk);                   // Middle of start bit.
      check(tx === 1'b0, "start bit on tx not low at mid-bit");
      for (int b = 0; b < 8; b++) begin
        repeat (BAUD_DIV) @(negedge clk);
        data[b] = tx;                                          // LSB first.
      end
      repeat (BAUD_DIV) @(negedge clk);
      check(tx === 1'b1, "stop bit on tx not high at mid-bit");
    end
  endtask

  // Decodes the frames of n_cmd commands: byte order, spacing and the cmd_snt flag.
  task automatic watch_tx(input int first, input int n_cmd);
    logic [7:0]  data;
    logic [7:0]  exp_b;
    logic [15:0] word;
    int          start_cyc;
    int          prev_start;
    int          waited;
    prev_start = -1;
    for (int k = 0; k < 2 * n_cmd; k++) begin
      word  = case_cmd[first + k / 2];
      exp_b = (k % 2 == 0) ? word[15:8] : word[7:0];          // High byte goes first.
      decode_frame(data, start_cyc);
      check(data === exp_b, $sformatf("frame %0d carries %h, expected %h", k, data, exp_b));
      if (prev_start >= 0) begin
        check(start_cyc - prev_start <= FRAME_CYC + 2,
              $sformatf("idle gap before frame %0d is longer than 2 cycles", k));
      end
      prev_start = start_cyc;
      // Flag is clear until the first command ends, then stays set.
      check(cmd_snt === (k >= 2 ? 1'b1 : 1'b0), $sformatf("cmd_snt wrong in frame %0d", k));
      if (k == 1) begin
        waited = 0;
        while (cmd_snt !== 1'b1 && waited < BAUD_DIV / 2 + 2) begin
          @(negedge clk);
          waited++;
        end
        check(cmd_snt === 1'b1, "cmd_snt not set within two cycles of the stop bit end");
        check(waited >= BAUD_DIV / 2, "cmd_snt set before the stop bit ended");
      end
    end
  endtask

  // Sends one response frame on rx and watches resp_rdy fall, then rise with the byte.
  task automatic send_resp(input logic [7:0] value);
    logic [9:0] frame;
    int         waited;
    bit         fell;
    frame = {1'b1, value, 1'b0};                               // Stop, data, start.
    fell  = (resp_rdy !== 1'b1);                               // Nothing to clear yet.
    fork
      begin
        for (int b = 0; b < 10; b++) begin
          rx = frame[b];
          repeat (BAUD_DIV) @(negedge clk);
        end
      end
      begin
        waited = 0;
        while (!(fell && resp_rdy === 1'b1) && waited < FRAME_CYC + 4) begin
          @(negedge clk);
          waited++;
          if (resp_rdy === 1'b0) fell = 1'b1;
        end
        check(fell, "resp_rdy did not fall after the start bit");
        check(resp_rdy === 1'b1, "resp_rdy not set within 10 bit times plus 4 cycles");
        check(resp === value, $sformatf("resp is %h, expected %h", resp, value));
      end
    join
  endtask

  // Waits for cmd_rdy, then pulses snd_cmd for one cycle.
  task automatic issue_cmd(input logic [15:0] word, input int limit);
    int waited;
    waited = 0;
    while (cmd_rdy !== 1'b1 && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    check(cmd_rdy === 1'b1, $sformatf("cmd_rdy low for %0d cycles", waited));
    cmd     = word;
    snd_cmd = 1'b1;
    @(negedge clk);
    snd_cmd = 1'b0;
    check(cmd_snt === 1'b0, "cmd_snt still set after an accepted command");
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    int                            fd;
    string                         line;
    logic [remote_pkg::CMD_W-1:0]  c;
    logic [remote_pkg::BYTE_W-1:0] r;
    int                            f;
    int                            n_grp;
    int                            err_before;
    int                            pass_cnt;
    int                            fail_cnt;
    int                            gap;
    snd_cmd  = 1'b0;
    cmd      = '0;
    rx       = 1'b1;                                           // Idle line.
    rst_n    = 1'b0;
    errors   = 0;
    n_cases  = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    void'($urandom(SEED));
    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      $display("ERROR: the case file %s could not be opened", CASE_FILE);
      errors++;
    end else begin
      while (!$feof(fd) && n_cases < MAX_CASES) begin
        if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
          if ($sscanf(line, "%h %h %d", c, r, f) == 3) begin
            case_cmd[n_cases]  = c;
            case_resp[n_cases] = r;
            case_flag[n_cases] = (f != 0);
            n_cases++;
          end
        end
      end
      $fclose(fd);
    end
    fork
      begin
        #((n_cases * 40 * BAUD_DIV + RESET_CYC) * CLK_PERIOD);
        $display("Timeout: the run took longer than its cases allow");
        $display("Verification failed");
        $finish;
      end
    join_none
    repeat (RESET_CYC) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    err_before = errors;
    check(tx === 1'b1, "tx not idle after reset");
    check(cmd_snt === 1'b0, "cmd_snt set after reset");
    check(resp_rdy === 1'b0, "resp_rdy set after reset");
    check(cmd_rdy === 1'b1, "cmd_rdy low after reset");
    if (errors == err_before) pass_cnt++;
    else fail_cnt++;
    $display("Reset state: %s", (errors == err_before) ? "ok" : "FAILED");
    for (int i = 0; i < n_cases; i += n_grp) begin
      n_grp      = (case_flag[i] && i + 1 < n_cases) ? 2 : 1;
      err_before = errors;
      if (i > 0) check(cmd_snt === 1'b1, "cmd_snt dropped before the next command");
      fork
        begin
          issue_cmd(case_cmd[i], 2);                           // FIFO is empty here.
          if (n_grp == 2) begin
            issue_cmd(case_cmd[i + 1], FRAME_CYC);             // While frame one is out.
            @(negedge clk);
            check(cmd_rdy === 1'b0, "cmd_rdy high with fewer than two free entries");
          end
        end
        watch_tx(i, n_grp);
        begin
          for (int j = 0; j < n_grp; j++) send_resp(case_resp[i + j]);
        end
      join
      for (int j = 0; j < n_grp; j++) begin
        if (errors == err_before) pass_cnt++;
        else fail_cnt++;
        $display("Case %0d cmd %h resp %h%s: %s", i + j, case_cmd[i + j], case_resp[i + j],
                 (n_grp == 2) ? " queued" : "", (errors == err_before) ? "ok" : "FAILED");
      end
      gap = $urandom_range(20, 0);                             // Idle time between cases.
      repeat (gap) @(negedge clk);
    end
    $display("Tests: %0d ok, %0d with errors, %0d failed checks", pass_cnt, fail_cnt, errors);
    if (errors == 0 && n_cases > 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== sim/remote_cases.txt ====
# Columns: command word (hex), response byte (hex), back-to-back flag (0 or 1).
# Flag 1 sends the command on the next line as soon as cmd_rdy allows.
A55A 3C 0
0001 80 0
FF00 01 1
1234 FE 0
8001 7E 0
00FF 55 1
C3E1 AA 0
7F80 0F 0
DEAD BE 1
BEEF EF 0

// ==== sources.f ====
hw/remote_pkg.sv
hw/cmd_splitter.sv
hw/byte_fifo.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/remote_comm.sv
sim/remote_comm_tb.sv

// ==== Makefile ====
# Verilator flow for the remote command link: make lint, make sim, make clean.
VERILATOR  ?= verilator
TB_TOP     ?= remote_comm_tb
RTL_TOP    ?= remote_comm
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -j 0
PASS_TEXT  ?= Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
	  echo "Simulation result: PASS"; \
	else \
	  echo "Simulation result: FAIL, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
